/* source/pcs_tx_pkg.sv */
// ====================
// PCS TX shared types
// ====================

package pcs_tx_pkg;

    // One 64b/66b block payload
    typedef logic [63:0] blk_data_t;

    // Sync header, 01 data and 10 control
    typedef logic [1:0] blk_sync_t;

    // Scrambler history, one bit per delay element
    typedef logic [57:0] scram_state_t;

    localparam blk_sync_t SYNC_CTRL = 2'b10;

    // Lane 0 style marker with the BIP fields left at zero
    localparam blk_data_t AM_PATTERN = 64'hC168_2100_3E97_DE00;

    localparam scram_state_t SCRAM_SEED = {58{1'b1}}; // State after reset

    // Taps of 1 + x^39 + x^58
    localparam int SCRAM_TAP_A = 39;
    localparam int SCRAM_TAP_B = 58;

endpackage

/* source/mii_blk_if.sv */
// ====================
// Block stream interface
// ====================

`timescale 1ns/1ps

interface mii_blk_if #(
    parameter int DATA_WD = 64
);

    logic [DATA_WD-1:0]    d;    // Block payload
    pcs_tx_pkg::blk_sync_t sync;
    logic                  vld;  // One block per high cycle
    logic                  am;   // Marker block, only with vld

    modport src (
        output d,
        output sync,
        output vld,
        output am
    );

    modport snk (
        input d,
        input sync,
        input vld,
        input am
    );

endinterface

/* source/scram_lane.sv */
// ====================
// 58-bit self-sync scrambler
// ====================

`timescale 1ns/1ps

module scram_lane #(
    parameter int DATA_WD = 64
) (
    input  logic               tclk,
    input  logic               rst_tclk,
    input  logic [DATA_WD-1:0] din,
    input  logic               din_valid,
    output logic [DATA_WD-1:0] dout,
    output logic               dout_valid
);

    localparam int TAP_A    = pcs_tx_pkg::SCRAM_TAP_A;
    localparam int TAP_B    = pcs_tx_pkg::SCRAM_TAP_B;
    localparam int STATE_WD = $bits(pcs_tx_pkg::scram_state_t);
    localparam int CHAIN_WD = STATE_WD + DATA_WD;

    logic [DATA_WD-1:0]       din_q;
    logic                     din_valid_q;
    pcs_tx_pkg::scram_state_t state;
    logic [CHAIN_WD-1:0]      chain;

    // Low bits hold the old state, newest history bit at STATE_WD-1.
    // Each scrambled bit lands above the history it was built from.
    function automatic logic [CHAIN_WD-1:0] scr_chain(
        input pcs_tx_pkg::scram_state_t st,
        input logic [DATA_WD-1:0]       d
    );
        logic [CHAIN_WD-1:0] c;
        c = '0;
        c[STATE_WD-1:0] = st;
        for (int i = 0; i < DATA_WD; i++) begin
            c[STATE_WD+i] = d[i] ^ c[STATE_WD+i-TAP_A] ^ c[STATE_WD+i-TAP_B];
        end
        return c;
    endfunction

    // Stage one
    always_ff @(posedge tclk) begin
        din_q <= din;
    end

    always_ff @(posedge tclk) begin
        if (rst_tclk) begin
            din_valid_q <= 1'b0;
        end else begin
            din_valid_q <= din_valid;
        end
    end

    assign chain = scr_chain(state, din_q);

    // Stage two, state moves only on a valid block
    always_ff @(posedge tclk) begin
        if (rst_tclk) begin
            state      <= pcs_tx_pkg::SCRAM_SEED;
            dout       <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid_q;
            if (din_valid_q) begin
                dout  <= chain[STATE_WD +: DATA_WD];
                state <= chain[DATA_WD +: STATE_WD]; // Last 58 scrambled bits
            end else begin
                dout <= din_q;                       // Idle or marker, untouched
            end
        end
    end

endmodule

/* source/scramble_new.sv */
// ====================
// TX scramble wrapper
// ====================

`timescale 1ns/1ps

module scramble_new #(
    parameter int DATA_WD = 64,
    parameter int BYPASS  = 0
) (
    input  logic                  tclk,
    input  logic                  rst_tclk,
    mii_blk_if.snk                blk,
    output pcs_tx_pkg::blk_data_t d_scr,
    output pcs_tx_pkg::blk_sync_t sync_scr,
    output logic                  vld,
    output logic                  am
);

    generate
        if (BYPASS != 0) begin : g_bypass
            // FlexE or OTN use, stream goes out as received
            always_ff @(posedge tclk) begin
                if (rst_tclk) begin
                    d_scr    <= '0;
                    sync_scr <= '0;
                    vld      <= 1'b0;
                    am       <= 1'b0;
                end else begin
                    d_scr    <= pcs_tx_pkg::blk_data_t'(blk.d);
                    sync_scr <= blk.sync;
                    vld      <= blk.vld;
                    am       <= blk.am;
                end
            end
        end else begin : g_scram
            logic [DATA_WD-1:0]    lane_dout;
            logic                  lane_vld;
            logic                  lane_din_vld;
            pcs_tx_pkg::blk_sync_t sync_q;
            logic                  am_q;

            // Markers bypass the scrambler and leave its state alone
            assign lane_din_vld = blk.vld & ~blk.am;

            scram_lane #(
                .DATA_WD (DATA_WD)
            ) scram_lane_i (
                .tclk       (tclk),
                .rst_tclk   (rst_tclk),
                .din        (blk.d),
                .din_valid  (lane_din_vld),
                .dout       (lane_dout),
                .dout_valid (lane_vld)
            );

            // Two flops to match the lane
            always_ff @(posedge tclk) begin
                if (rst_tclk) begin
                    sync_q   <= '0;
                    sync_scr <= '0;
                    am_q     <= 1'b0;
                    am       <= 1'b0;
                end else begin
                    sync_q   <= blk.sync;
                    sync_scr <= sync_q;
                    am_q     <= blk.am;
                    am       <= am_q;
                end
            end

            assign d_scr = pcs_tx_pkg::blk_data_t'(lane_dout);
            assign vld   = lane_vld | am; // Lane valid never covers a marker
        end
    endgenerate

endmodule

/* source/am_inserter.sv */
// ====================
// Alignment marker insert
// ====================

`timescale 1ns/1ps

module am_inserter #(
    parameter int DATA_WD   = 64,
    parameter int AM_PERIOD = 16
) (
    input  logic                  tclk,
    input  logic                  rst_tclk,
    input  pcs_tx_pkg::blk_data_t in_d,
    input  pcs_tx_pkg::blk_sync_t in_sync,
    input  logic                  in_vld,
    mii_blk_if.src                blk
);

    localparam int CNT_WD = $clog2(AM_PERIOD + 1);
    localparam logic [CNT_WD-1:0] CNT_LAST = CNT_WD'(AM_PERIOD - 1);

    logic [CNT_WD-1:0] blk_cnt;
    logic              am_pend;
    logic              am_slot;

    // First idle cycle with a marker owed
    assign am_slot = am_pend & ~in_vld;

    // Data block count and pending marker
    always_ff @(posedge tclk) begin
        if (rst_tclk) begin
            blk_cnt <= '0;
            am_pend <= 1'b0;
        end else begin
            if (in_vld) begin
                if (blk_cnt == CNT_LAST) begin
                    blk_cnt <= '0;
                    am_pend <= 1'b1;
                end else begin
                    blk_cnt <= blk_cnt + 1'b1;
                end
            end else if (am_slot) begin
                am_pend <= 1'b0;
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge tclk) begin
        if (am_slot) begin
            blk.d    <= DATA_WD'(pcs_tx_pkg::AM_PATTERN);
            blk.sync <= pcs_tx_pkg::SYNC_CTRL;
        end else begin
            blk.d    <= DATA_WD'(in_d);
            blk.sync <= in_sync;
        end
    end

    always_ff @(posedge tclk) begin
        if (rst_tclk) begin
            blk.vld <= 1'b0;
            blk.am  <= 1'b0;
        end else begin
            blk.vld <= in_vld | am_slot;
            blk.am  <= am_slot;
        end
    end

endmodule

/* source/pcs_tx_top.sv */
// ====================
// PCS TX slice top
// ====================

`timescale 1ns/1ps

module pcs_tx_top #(
    parameter int DATA_WD   = 64,
    parameter int BYPASS    = 0,
    parameter int AM_PERIOD = 16
) (
    input  logic                  tclk,
    input  logic                  rst_tclk,

    // From the encoder side
    input  pcs_tx_pkg::blk_data_t tx_d,
    input  pcs_tx_pkg::blk_sync_t tx_sync,
    input  logic                  tx_vld,

    // Towards the gearbox
    output pcs_tx_pkg::blk_data_t tx_d_scr,
    output pcs_tx_pkg::blk_sync_t tx_sync_scr,
    output logic                  tx_vld_scr,
    output logic                  tx_am
);

    mii_blk_if #(
        .DATA_WD (DATA_WD)
    ) blk_am ();

    am_inserter #(
        .DATA_WD   (DATA_WD),
        .AM_PERIOD (AM_PERIOD)
    ) am_inserter_i (
        .tclk     (tclk),
        .rst_tclk (rst_tclk),
        .in_d     (tx_d),
        .in_sync  (tx_sync),
        .in_vld   (tx_vld),
        .blk      (blk_am.src)
    );

    scramble_new #(
        .DATA_WD (DATA_WD),
        .BYPASS  (BYPASS)
    ) scramble_new_i (
        .tclk     (tclk),
        .rst_tclk (rst_tclk),
        .blk      (blk_am.snk),
        .d_scr    (tx_d_scr),
        .sync_scr (tx_sync_scr),
        .vld      (tx_vld_scr),
        .am       (tx_am)
    );

endmodule

/* tests/tb_pcs_tx_util.svh */
// ====================
// PCS TX testbench helpers
// ====================

`ifndef TB_PCS_TX_UTIL_SVH
`define TB_PCS_TX_UTIL_SVH

task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
        fail_run($sformatf("mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act));
    end
endtask

// x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// Serial form of 1 + x^39 + x^58, st[0] is the newest scrambled bit
function automatic logic [63:0] scramble_model(
    input  logic [63:0] d,
    input  logic [57:0] st_in,
    output logic [57:0] st_out
);
    logic [57:0] st;
    logic [63:0] q;
    logic        s;
    st = st_in;
    q  = '0;
    for (int i = 0; i < 64; i++) begin
        s    = d[i] ^ st[pcs_tx_pkg::SCRAM_TAP_A-1] ^ st[pcs_tx_pkg::SCRAM_TAP_B-1];
        q[i] = s;
        st   = {st[56:0], s};
    end
    st_out = st;
    return q;
endfunction

task automatic wait_drained(input string what);
    int n;
    n = 0;
    while ((exp_scr_q.size() != 0 || exp_byp_q.size() != 0) && n < TIMEOUT) begin
        @(posedge tclk);
        n++;
    end
    if (exp_scr_q.size() != 0 || exp_byp_q.size() != 0) begin
        fail_run($sformatf("timeout: %s blocks still owed after %0d cycles", what, TIMEOUT));
    end
endtask

task automatic wait_marker(input int target_scr, input int target_byp);
    int n;
    n = 0;
    while ((am_seen_scr < target_scr || am_seen_byp < target_byp) && n < TIMEOUT) begin
        @(posedge tclk);
        n++;
    end
    if (am_seen_scr < target_scr || am_seen_byp < target_byp) begin
        fail_run($sformatf("timeout: no alignment marker came out within %0d cycles", TIMEOUT));
    end
endtask

`endif

/* tests/tb_pcs_tx.sv */
// ====================
// PCS TX testbench
// ====================

`timescale 1ns/1ps

module tb_pcs_tx;

    localparam int AM_PERIOD = 8;
    localparam int LAT_SCR   = 3;
    localparam int LAT_BYP   = 2;
    localparam int TIMEOUT   = 200;

    typedef struct packed {
        logic [63:0] d;
        logic [1:0]  sync;
        logic        am;
        logic [31:0] cyc;   // Cycle the block went in
    } exp_blk_t;

    logic                  tclk;
    logic                  rst_tclk;
    pcs_tx_pkg::blk_data_t tx_d;
    pcs_tx_pkg::blk_sync_t tx_sync;
    logic                  tx_vld;
    pcs_tx_pkg::blk_data_t tx_d_scr;
    pcs_tx_pkg::blk_sync_t tx_sync_scr;
    logic                  tx_vld_scr;
    logic                  tx_am_scr;
    pcs_tx_pkg::blk_data_t tx_d_byp;
    pcs_tx_pkg::blk_sync_t tx_sync_byp;
    logic                  tx_vld_byp;
    logic                  tx_am_byp;

    exp_blk_t    exp_scr_q[$];
    exp_blk_t    exp_byp_q[$];
    logic [57:0] model_st;
    int          model_cnt;
    logic        model_pend;
    int          am_seen_scr;
    int          am_seen_byp;
    logic [15:0] lfsr_st;
    logic [31:0] cyc;
    string       test_name;

    `include "tb_pcs_tx_util.svh"

    pcs_tx_top #(
        .DATA_WD   (64),
        .BYPASS    (0),
        .AM_PERIOD (AM_PERIOD)
    ) pcs_tx_top_i (
        .tclk        (tclk),
        .rst_tclk    (rst_tclk),
        .tx_d        (tx_d),
        .tx_sync     (tx_sync),
        .tx_vld      (tx_vld),
        .tx_d_scr    (tx_d_scr),
        .tx_sync_scr (tx_sync_scr),
        .tx_vld_scr  (tx_vld_scr),
        .tx_am       (tx_am_scr)
    );

    pcs_tx_top #(
        .DATA_WD   (64),
        .BYPASS    (1),
        .AM_PERIOD (AM_PERIOD)
    ) pcs_tx_top_byp_i (
        .tclk        (tclk),
        .rst_tclk    (rst_tclk),
        .tx_d        (tx_d),
        .tx_sync     (tx_sync),
        .tx_vld      (tx_vld),
        .tx_d_scr    (tx_d_byp),
        .tx_sync_scr (tx_sync_byp),
        .tx_vld_scr  (tx_vld_byp),
        .tx_am       (tx_am_byp)
    );

    initial begin
        tclk = 1'b0;
        cyc  = '0;
        forever #2 tclk = ~tclk;
    end

    always @(posedge tclk) begin
        cyc <= cyc + 32'd1;
    end

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_st = lfsr_next(lfsr_st);
            r       = {r[62:0], lfsr_st[0]};
        end
        return r;
    endfunction

    task automatic push_block(input logic [63:0] d_scr, input logic [63:0] d_raw,
                              input logic [1:0] sync, input logic am);
        exp_blk_t e;
        e.sync = sync;
        e.am   = am;
        e.cyc  = cyc;
        e.d    = d_scr;
        exp_scr_q.push_back(e);
        e.d    = d_raw;
        exp_byp_q.push_back(e);
    endtask

    // One input cycle plus the model step for it
    task automatic drive_block(input logic v);
        logic [63:0] d;
        logic [1:0]  sync;
        logic [63:0] d_scr;
        logic [57:0] st_next;
        @(posedge tclk);
        #1;
        d       = rand_bits(64);
        sync    = (rand_bits(1) == 64'd1) ? 2'b10 : 2'b01;
        tx_d    = d;
        tx_sync = sync;
        tx_vld  = v;
        if (v) begin
            d_scr    = scramble_model(d, model_st, st_next);
            model_st = st_next;
            push_block(d_scr, d, sync, 1'b0);
            model_cnt++;
            if (model_cnt == AM_PERIOD) begin
                model_cnt  = 0;
                model_pend = 1'b1;
            end
        end else if (model_pend) begin
            // Marker takes this idle slot, state untouched
            push_block(pcs_tx_pkg::AM_PATTERN, pcs_tx_pkg::AM_PATTERN, pcs_tx_pkg::SYNC_CTRL, 1'b1);
            model_pend = 1'b0;
        end
    endtask

    task automatic reset_model();
        exp_scr_q.delete();
        exp_byp_q.delete();
        model_st   = pcs_tx_pkg::SCRAM_SEED;
        model_cnt  = 0;
        model_pend = 1'b0;
    endtask

    task automatic check_output(input string dut, input exp_blk_t e, input int lat,
                                input logic [63:0] d, input logic [1:0] sync, input logic am);
        check_value({dut, " data"}, e.d, d);
        check_value({dut, " sync"}, 64'(e.sync), 64'(sync));
        check_value({dut, " am"}, 64'(e.am), 64'(am));
        check_value({dut, " latency"}, 64'(lat), 64'(cyc - e.cyc));
    endtask

    // Outputs settle after the rising edge, sampled mid cycle
    always @(negedge tclk) begin : out_monitor
        exp_blk_t e;
        if (tx_vld_scr === 1'b1) begin
            if (exp_scr_q.size() == 0) begin
                fail_run("scrambling DUT put out a block that was never expected");
            end else begin
                e = exp_scr_q.pop_front();
                check_output("scr", e, LAT_SCR, tx_d_scr, tx_sync_scr, tx_am_scr);
                if (tx_am_scr) am_seen_scr++;
            end
        end
        if (tx_vld_byp === 1'b1) begin
            if (exp_byp_q.size() == 0) begin
                fail_run("bypass DUT put out a block that was never expected");
            end else begin
                e = exp_byp_q.pop_front();
                check_output("byp", e, LAT_BYP, tx_d_byp, tx_sync_byp, tx_am_byp);
                if (tx_am_byp) am_seen_byp++;
            end
        end
    end

    task automatic test_idle_after_reset();
        test_name = "idle_after_reset";
        for (int i = 0; i < 4; i++) begin
            drive_block(1'b0);
            @(negedge tclk);
            check_value("scr vld", 64'd0, 64'(tx_vld_scr));
            check_value("scr am", 64'd0, 64'(tx_am_scr));
            check_value("byp vld", 64'd0, 64'(tx_vld_byp));
            check_value("byp am", 64'd0, 64'(tx_am_byp));
        end
    endtask

    task automatic test_continuous();
        test_name = "continuous";
        for (int i = 0; i < 6; i++) begin
            drive_block(1'b1);
        end
        drive_block(1'b0);
        wait_drained("continuous");
    endtask

    task automatic test_gaps();
        logic [11:0] pattern;
        test_name = "gaps";
        pattern   = 12'b1011_0011_0101;
        for (int i = 11; i >= 0; i--) begin
            drive_block(pattern[i]);
        end
        drive_block(1'b0);
        wait_drained("gaps");
    endtask

    task automatic test_marker();
        int seen_scr;
        int seen_byp;
        test_name = "marker";
        seen_scr  = am_seen_scr;
        seen_byp  = am_seen_byp;
        for (int i = 0; i < AM_PERIOD; i++) begin
            drive_block(1'b1);
        end
        drive_block(1'b0);    // Slot for the owed marker
        for (int i = 0; i < 4; i++) begin
            drive_block(1'b1);
        end
        drive_block(1'b0);
        wait_marker(seen_scr + 1, seen_byp + 1);
        wait_drained("marker");
    endtask

    task automatic test_bypass();
        test_name = "bypass";
        for (int i = 0; i < 32; i++) begin
            drive_block(rand_bits(2) != 64'd0);   // About three in four valid
        end
        drive_block(1'b0);
        wait_drained("bypass");
    endtask

    task automatic test_reset_mid();
        test_name = "reset_mid";
        for (int i = 0; i < 5; i++) begin
            drive_block(1'b1);
        end
        @(posedge tclk);
        #1;
        rst_tclk = 1'b1;
        tx_vld   = 1'b0;
        repeat (2) @(posedge tclk);
        reset_model();    // Blocks in flight are gone
        repeat (6) @(posedge tclk);
        #1;
        rst_tclk = 1'b0;
        for (int i = 0; i < 3; i++) begin
            drive_block(1'b1);
        end
        drive_block(1'b0);
        wait_drained("reset_mid");
    endtask

    initial begin
        rst_tclk  = 1'b1;
        tx_d      = '0;
        tx_sync   = 2'b01;
        tx_vld    = 1'b0;
        lfsr_st   = 16'd39;
        am_seen_scr = 0;
        am_seen_byp = 0;
        test_name = "reset";
        reset_model();
        repeat (8) @(posedge tclk);
        #1;
        rst_tclk = 1'b0;

        test_idle_after_reset();
        test_continuous();
        test_gaps();
        test_marker();
        test_bypass();
        test_reset_mid();

        if (exp_scr_q.size() != 0 || exp_byp_q.size() != 0) begin
            fail_run("expected blocks left unchecked at the end of the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+tests
source/pcs_tx_pkg.sv
source/mii_blk_if.sv
source/scram_lane.sv
source/scramble_new.sv
source/am_inserter.sv
source/pcs_tx_top.sv
tests/tb_pcs_tx.sv

/* run.sh */
#!/bin/sh
# Build and run the PCS TX testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_pcs_tx \
    -f vlog.f \
    -o Vtb_pcs_tx

# The testbench stops with a nonzero status on error, the grep decides
sim_out=$(./obj_dir/Vtb_pcs_tx 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "ALL CHECKS PASSED"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
